/* verilog/ippcrc_pkg.sv */
`default_nettype none

package ippcrc_pkg;

    // Datapath widths
    localparam int CRC_W  = 12;
    localparam int DATA_W = 48;

    // x^12+x^11+x^3+x^2+x+1, top term implied
    localparam logic [CRC_W-1:0] CRC_POLY = 12'h80F;

    // Register word indices, taken from adr[3:2]
    localparam logic [1:0] ADDR_DATA_LO = 2'd0;  // Low 32 bits of staged word
    localparam logic [1:0] ADDR_DATA_HI = 2'd1;  // High 16 bits, write pushes word
    localparam logic [1:0] ADDR_SEED    = 2'd2;  // Running CRC seed
    localparam logic [1:0] ADDR_STATUS  = 2'd3;  // CRC and busy flag

    // Busy flag position in the status word
    localparam int STATUS_BUSY_BIT = 16;

endpackage

`default_nettype wire

/* verilog/ippcrc_crc12_48b.sv */
`timescale 1ns/10ps
`default_nettype none

// One-word CRC-12 update, purely combinational.
// The 48 data bits enter LSB first, and each bit is XORed with the
// current CRC MSB to form the feedback that selects the polynomial.
module ippcrc_crc12_48b
    import ippcrc_pkg::*;
(
    input  logic [CRC_W-1:0]  ci,  // CRC before this word
    input  logic [DATA_W-1:0] di,  // Data word, di[0] shifted in first
    output logic [CRC_W-1:0]  co   // CRC after this word
);

    // Serial LFSR form, unrolled by the loop into a parallel XOR tree
    function automatic logic [CRC_W-1:0] fold_word(
        input logic [CRC_W-1:0]  crc_in,
        input logic [DATA_W-1:0] data_in
    );
        logic [CRC_W-1:0] c;
        logic             fb;
        c = crc_in;
        for (int i = 0; i < DATA_W; i++) begin
            fb = c[CRC_W-1] ^ data_in[i];   // Feedback from the MSB
            c  = {c[CRC_W-2:0], 1'b0};
            if (fb) begin
                c = c ^ CRC_POLY;
            end
        end
        return c;
    endfunction

    assign co = fold_word(ci, di);

endmodule

`default_nettype wire

/* verilog/ippcrc_wb_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module ippcrc_wb_regs
    import ippcrc_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              cyc,
    input  logic              stb,
    input  logic              we,
    input  logic [3:0]        adr,
    input  logic [31:0]       dat_w,
    input  logic [3:0]        sel,          // Byte enables, all writes are full word
    input  logic              full,
    input  logic              busy,
    input  logic [CRC_W-1:0]  crc,
    output logic              ack,
    output logic [31:0]       dat_r,
    output logic              push,
    output logic [DATA_W-1:0] push_data,
    output logic              seed_load,
    output logic [CRC_W-1:0]  seed_value
);

    localparam int HI_W = DATA_W - 32;      // Width of the upper half of a word

    logic            req;
    logic [1:0]      word_idx;
    logic            is_lo;
    logic            is_hi;
    logic            is_seed;
    logic            is_status;
    logic            plain_ack;
    logic            ack_next;
    logic [31:0]     data_lo;
    logic [HI_W-1:0] data_hi;
    logic [31:0]     status_word;
    logic [31:0]     rd_mux;

    // A request is new until it has been acknowledged
    assign req      = cyc & stb & ~ack;
    assign word_idx = adr[3:2];

    assign is_lo     = (word_idx == ADDR_DATA_LO);
    assign is_hi     = (word_idx == ADDR_DATA_HI);
    assign is_seed   = (word_idx == ADDR_SEED);
    assign is_status = (word_idx == ADDR_STATUS);

    // DATA_HI write waits for a free FIFO slot
    assign push      = req & we & is_hi & ~full;
    assign push_data = {dat_w[HI_W-1:0], data_lo};

    // SEED write waits until the pipeline has drained
    assign seed_load  = req & we & is_seed & ~busy;
    assign seed_value = dat_w[CRC_W-1:0];

    // Reads and the remaining writes never stall
    assign plain_ack = req & (~we | is_lo | is_status);
    assign ack_next  = plain_ack | push | seed_load;

    always_comb begin
        status_word                  = '0;
        status_word[CRC_W-1:0]       = crc;
        status_word[STATUS_BUSY_BIT] = busy;
    end

    always_comb begin
        case (word_idx)
            ADDR_DATA_LO: rd_mux = data_lo;
            ADDR_DATA_HI: rd_mux = {{(32-HI_W){1'b0}}, data_hi};
            ADDR_SEED:    rd_mux = {{(32-CRC_W){1'b0}}, crc};   // Seed lives in the CRC
            default:      rd_mux = status_word;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ack     <= 1'b0;
            data_lo <= '0;
            data_hi <= '0;
        end else begin
            ack <= ack_next;                  // One-cycle pulse, req blocks a repeat
            if (req & we & is_lo) begin
                data_lo <= dat_w;
            end
            if (push) begin
                data_hi <= dat_w[HI_W-1:0];   // Kept for read back
            end
        end
    end

    // Read data is captured with the acknowledge
    always_ff @(posedge clk) begin
        if (req & ~we) begin
            dat_r <= rd_mux;
        end
    end

endmodule

`default_nettype wire

/* verilog/ippcrc_word_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

module ippcrc_word_fifo
    import ippcrc_pkg::*;
#(
    parameter int DEPTH = 4                 // Power of two, at least 2
)
(
    input  logic              clk,
    input  logic              reset,
    input  logic              push,
    input  logic [DATA_W-1:0] push_data,
    input  logic              pop,
    output logic [DATA_W-1:0] pop_data,
    output logic              full,
    output logic              empty
);

    localparam int AW = $clog2(DEPTH);

    logic [DATA_W-1:0] mem [DEPTH];
    logic [AW-1:0]     wr_ptr;
    logic [AW-1:0]     rd_ptr;
    logic [AW:0]       count;
    logic              do_push;
    logic              do_pop;

    assign full  = (count == (AW+1)'(DEPTH));
    assign empty = (count == '0);

    // When full, a push is still taken if the head leaves in the same cycle
    assign do_pop  = pop & ~empty;
    assign do_push = push & (~full | do_pop);

    // First word falls through to the output
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;      // Wraps at DEPTH
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;      // Both or neither
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/ippcrc_step_stage.sv */
`timescale 1ns/10ps
`default_nettype none

// Two-step fold: the popped word is registered first, then folded into
// the running CRC on the following edge, so the FIFO can deliver a new
// word every cycle.
module ippcrc_step_stage
    import ippcrc_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              empty,
    input  logic [DATA_W-1:0] pop_data,
    input  logic              seed_load,
    input  logic [CRC_W-1:0]  seed_value,
    output logic              pop,
    output logic [CRC_W-1:0]  crc,
    output logic              stage_busy
);

    logic [DATA_W-1:0] word_q;
    logic [CRC_W-1:0]  crc_next;

    // Always ready, take every word the FIFO offers
    assign pop = ~empty;

    ippcrc_crc12_48b crc_i (
        .ci (crc),
        .di (word_q),
        .co (crc_next)
    );

    // Popped word holding register
    always_ff @(posedge clk) begin
        if (pop) begin
            word_q <= pop_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            stage_busy <= 1'b0;
            crc        <= '0;
        end else begin
            stage_busy <= pop;                // word_q holds a word to fold
            if (seed_load) begin
                crc <= seed_value;            // Only issued while idle
            end else if (stage_busy) begin
                crc <= crc_next;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/ippcrc_top.sv */
`timescale 1ns/10ps
`default_nettype none

module ippcrc_top
    import ippcrc_pkg::*;
#(
    parameter int FIFO_DEPTH = 4
)
(
    input  logic        clk,
    input  logic        reset,
    input  logic        cyc,
    input  logic        stb,
    input  logic        we,
    input  logic [3:0]  adr,
    input  logic [31:0] dat_w,
    input  logic [3:0]  sel,
    output logic        ack,
    output logic [31:0] dat_r
);

    logic              push;
    logic [DATA_W-1:0] push_data;
    logic              full;
    logic              pop;
    logic [DATA_W-1:0] pop_data;
    logic              empty;
    logic              seed_load;
    logic [CRC_W-1:0]  seed_value;
    logic [CRC_W-1:0]  crc;
    logic              stage_busy;
    logic              busy;

    // Words queued or one still being folded
    assign busy = stage_busy | ~empty;

    ippcrc_wb_regs regs_i (
        .clk        (clk),
        .reset      (reset),
        .cyc        (cyc),
        .stb        (stb),
        .we         (we),
        .adr        (adr),
        .dat_w      (dat_w),
        .sel        (sel),
        .full       (full),
        .busy       (busy),
        .crc        (crc),
        .ack        (ack),
        .dat_r      (dat_r),
        .push       (push),
        .push_data  (push_data),
        .seed_load  (seed_load),
        .seed_value (seed_value)
    );

    ippcrc_word_fifo #(
        .DEPTH (FIFO_DEPTH)
    ) fifo_i (
        .clk       (clk),
        .reset     (reset),
        .push      (push),
        .push_data (push_data),
        .pop       (pop),
        .pop_data  (pop_data),
        .full      (full),
        .empty     (empty)
    );

    ippcrc_step_stage step_i (
        .clk        (clk),
        .reset      (reset),
        .empty      (empty),
        .pop_data   (pop_data),
        .seed_load  (seed_load),
        .seed_value (seed_value),
        .pop        (pop),
        .crc        (crc),
        .stage_busy (stage_busy)
    );

endmodule

`default_nettype wire

/* tb/ippcrc_checker.sv */
`timescale 1ns/10ps
`default_nettype none

// Watches the Wishbone port, keeps a shadow of the register state and
// compares read data against it
module ippcrc_checker
    import ippcrc_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        cyc,
    input  logic        stb,
    input  logic        we,
    input  logic [3:0]  adr,
    input  logic [31:0] dat_w,
    input  logic        ack,
    input  logic [31:0] dat_r,
    output int          check_count,
    output int          error_count
);

    localparam int HI_W = DATA_W - 32;

    logic [CRC_W-1:0] shadow_crc;
    logic [31:0]      shadow_lo;
    logic [HI_W-1:0]  shadow_hi;

    // Bit-serial CRC-12, data LSB first, divisor with its x^12 term
    function automatic logic [CRC_W-1:0] ref_crc(
        input logic [CRC_W-1:0]  crc_in,
        input logic [DATA_W-1:0] word
    );
        logic [CRC_W:0]   r;
        logic [CRC_W-1:0] crc;
        crc = crc_in;
        for (int b = 0; b < DATA_W; b++) begin
            r = {crc, 1'b0};
            if (r[CRC_W] ^ word[b]) begin
                r = r ^ {1'b1, CRC_POLY};
            end
            crc = r[CRC_W-1:0];
        end
        return crc;
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAILED %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    initial begin
        check_count = 0;
        error_count = 0;
    end

    // Sampled mid-cycle, where ack and dat_r are settled
    always @(negedge clk) begin
        if (reset) begin
            shadow_crc = '0;
            shadow_lo  = '0;
            shadow_hi  = '0;
        end else if (cyc && stb && ack) begin
            if (we) begin
                case (adr[3:2])
                    ADDR_DATA_LO: shadow_lo = dat_w;
                    ADDR_DATA_HI: begin
                        shadow_hi  = dat_w[HI_W-1:0];
                        shadow_crc = ref_crc(shadow_crc, {dat_w[HI_W-1:0], shadow_lo});
                    end
                    ADDR_SEED:    shadow_crc = dat_w[CRC_W-1:0];
                    default:      ;                   // STATUS is read only
                endcase
            end else begin
                case (adr[3:2])
                    ADDR_DATA_LO: compare("dat_r DATA_LO", dat_r, shadow_lo);
                    ADDR_DATA_HI: compare("dat_r DATA_HI", dat_r, {{(32-HI_W){1'b0}}, shadow_hi});
                    ADDR_STATUS: begin
                        // A busy result is still moving
                        if (!dat_r[STATUS_BUSY_BIT]) begin
                            compare("dat_r STATUS crc", {{(32-CRC_W){1'b0}}, dat_r[CRC_W-1:0]},
                                    {{(32-CRC_W){1'b0}}, shadow_crc});
                        end
                    end
                    default:      ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* tb/ippcrc_properties.sv */
`timescale 1ns/10ps
`default_nettype none

module ippcrc_properties
    import ippcrc_pkg::*;
(
    input logic       clk,
    input logic       reset,
    input logic       cyc,
    input logic       stb,
    input logic       we,
    input logic [3:0] adr,
    input logic       ack,
    input logic       push
);

    int assert_failures = 0;

    ack_in_request: assert property (@(posedge clk) disable iff (reset) ack |-> (cyc && stb))
        else begin
            $error("ack raised outside a bus request");
            assert_failures++;
        end

    ack_single_pulse: assert property (@(posedge clk) disable iff (reset) ack |=> !ack)
        else begin
            $error("ack held high for two cycles");
            assert_failures++;
        end

    // A word write is only acknowledged once it went into the FIFO
    hi_ack_after_push: assert property (@(posedge clk) disable iff (reset)
            (ack && we && adr[3:2] == ADDR_DATA_HI) |-> $past(push))
        else begin
            $error("DATA_HI write acknowledged without a FIFO push");
            assert_failures++;
        end

endmodule

bind ippcrc_top ippcrc_properties props_i (
    .clk   (clk),
    .reset (reset),
    .cyc   (cyc),
    .stb   (stb),
    .we    (we),
    .adr   (adr),
    .ack   (ack),
    .push  (push)
);

`default_nettype wire

/* tb/ippcrc_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module ippcrc_tb
    import ippcrc_pkg::*;
();

    localparam int PERIOD     = 40;
    localparam int DRIVE_DLY  = 2;       // Inputs change this long after the rising edge
    localparam int NUM_WORDS  = 16;
    localparam int POLL_LIMIT = 50;

    logic        clk;
    logic        reset;
    logic        cyc;
    logic        stb;
    logic        we;
    logic [3:0]  adr;
    logic [31:0] dat_w;
    logic [3:0]  sel;
    logic        ack;
    logic [31:0] dat_r;

    int cycle_count = 0;
    int transfers   = 0;
    int tb_errors   = 0;
    int check_count;
    int error_count;

    ippcrc_top #(
        .FIFO_DEPTH (4)
    ) dut_i (
        .clk   (clk),
        .reset (reset),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .dat_w (dat_w),
        .sel   (sel),
        .ack   (ack),
        .dat_r (dat_r)
    );

    ippcrc_checker checker_i (
        .clk         (clk),
        .reset       (reset),
        .cyc         (cyc),
        .stb         (stb),
        .we          (we),
        .adr         (adr),
        .dat_w       (dat_w),
        .ack         (ack),
        .dat_r       (dat_r),
        .check_count (check_count),
        .error_count (error_count)
    );

    always #(PERIOD/2) clk = ~clk;

    // Limit grows with every transfer issued
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > 20 * transfers + 200) begin
            $display("Timeout after %0d cycles with %0d bus transfers issued",
                     cycle_count, transfers);
            $display("tests failed");
            $finish;
        end
    end

    task automatic await_ack(output logic [31:0] data);
        do @(negedge clk); while (ack !== 1'b1);
        data = dat_r;
        @(posedge clk);
        #DRIVE_DLY;
        cyc = 1'b0;                          // Drop the request in the cycle after ack
        stb = 1'b0;
        we  = 1'b0;
    endtask

    task automatic write_reg(input logic [1:0] idx, input logic [31:0] data);
        logic [31:0] unused_rd;
        @(posedge clk);
        #DRIVE_DLY;
        transfers++;
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = 1'b1;
        adr   = {idx, 2'b00};
        dat_w = data;
        sel   = 4'hF;
        await_ack(unused_rd);
    endtask

    task automatic read_reg(input logic [1:0] idx, output logic [31:0] data);
        @(posedge clk);
        #DRIVE_DLY;
        transfers++;
        cyc = 1'b1;
        stb = 1'b1;
        we  = 1'b0;
        adr = {idx, 2'b00};
        sel = 4'hF;
        await_ack(data);
    endtask

    task automatic send_word(input logic [DATA_W-1:0] word);
        write_reg(ADDR_DATA_LO, word[31:0]);
        write_reg(ADDR_DATA_HI, {16'h0, word[DATA_W-1:32]});   // Pushes the word
    endtask

    // The SEED request follows the DATA_HI acknowledge with no idle cycle,
    // so it reaches the DUT while the pushed word is still being folded
    task automatic send_word_then_seed(input logic [DATA_W-1:0] word,
                                       input logic [CRC_W-1:0]  seed);
        logic [31:0] unused_rd;
        write_reg(ADDR_DATA_LO, word[31:0]);
        @(posedge clk);
        #DRIVE_DLY;
        transfers++;
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = 1'b1;
        adr   = {ADDR_DATA_HI, 2'b00};
        dat_w = {16'h0, word[DATA_W-1:32]};
        do @(negedge clk); while (ack !== 1'b1);
        @(posedge clk);
        #DRIVE_DLY;
        transfers++;
        adr   = {ADDR_SEED, 2'b00};
        dat_w = {20'h0, seed};
        repeat (2) @(negedge clk);           // A plain access would be acknowledged by now
        if (ack !== 1'b0) begin
            tb_errors++;
            $display("SEED write acknowledged while a word was still being folded");
        end
        await_ack(unused_rd);
    endtask

    task automatic expect_idle(input logic [31:0] status);
        if (status[STATUS_BUSY_BIT]) begin
            tb_errors++;
            $display("FAILED dat_r[%0d] busy: got 0x1 expected 0x0", STATUS_BUSY_BIT);
        end
    endtask

    task automatic poll_until_idle();
        logic [31:0] status;
        int          polls;
        polls = 0;
        do begin
            read_reg(ADDR_STATUS, status);
            polls++;
        end while (status[STATUS_BUSY_BIT] && polls < POLL_LIMIT);
        if (status[STATUS_BUSY_BIT]) begin
            tb_errors++;
            $display("Busy flag still set after %0d status reads", polls);
        end
    endtask

    initial begin
        logic [DATA_W-1:0] word;
        logic [CRC_W-1:0]  seed;
        logic [31:0]       rd;
        int                total;
        clk      = 1'b0;
        reset    = 1'b1;
        cyc      = 1'b0;
        stb      = 1'b0;
        we       = 1'b0;
        adr      = '0;
        dat_w    = '0;
        sel      = '0;
        void'($urandom(75));
        repeat (2) @(posedge clk);
        #DRIVE_DLY;
        reset = 1'b0;

        read_reg(ADDR_STATUS, rd);           // Reset state, CRC zero and idle
        expect_idle(rd);

        seed = 12'($urandom);                // Seed then one word
        write_reg(ADDR_SEED, {20'h0, seed});
        word = {16'($urandom), 32'($urandom)};
        send_word(word);
        poll_until_idle();

        for (int i = 0; i < NUM_WORDS; i++) begin
            word = {16'($urandom), 32'($urandom)};
            send_word(word);
        end
        poll_until_idle();

        for (int i = 0; i < 2; i++) begin
            word = {16'($urandom), 32'($urandom)};
            send_word(word);
        end
        word = {16'($urandom), 32'($urandom)};
        seed = 12'($urandom);
        send_word_then_seed(word, seed);     // Held off until the word is folded
        read_reg(ADDR_STATUS, rd);
        expect_idle(rd);
        word = {16'($urandom), 32'($urandom)};
        send_word(word);
        poll_until_idle();

        word = {16'($urandom), 32'($urandom)};
        send_word(word);
        poll_until_idle();
        read_reg(ADDR_DATA_LO, rd);
        read_reg(ADDR_DATA_HI, rd);
        read_reg(ADDR_STATUS, rd);           // CRC must not move on data reads
        expect_idle(rd);

        if (check_count == 0) begin
            tb_errors++;
            $display("No read results were compared");
        end
        total = error_count + tb_errors + dut_i.props_i.assert_failures;
        $display("Summary: %0d checks, %0d checker, %0d testbench, %0d assertion errors",
                 check_count, error_count, tb_errors, dut_i.props_i.assert_failures);
        if (total == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* ippcrc.f */
verilog/ippcrc_pkg.sv
verilog/ippcrc_crc12_48b.sv
verilog/ippcrc_wb_regs.sv
verilog/ippcrc_word_fifo.sv
verilog/ippcrc_step_stage.sv
verilog/ippcrc_top.sv
tb/ippcrc_checker.sv
tb/ippcrc_properties.sv
tb/ippcrc_tb.sv

/* Makefile */
# Verilator build and run for the CRC-12 accelerator testbench

VERILATOR ?= verilator
TOP       ?= ippcrc_tb
FILELIST  ?= ippcrc.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary -j 0 --timing --assert --timescale 1ns/10ps
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= all tests passed

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_EXE := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_EXE)

$(SIM_EXE): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	$(SIM_EXE) $(SIM_ARGS) | tee /dev/stderr | grep -qx '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
